// File: Bender.yml
package:
  name: spike_source

sources:
  - spike_pkg.sv
  - gen_state_ram.sv
  - spike_gen_bank.sv
  - spike_merge.sv
  - spike_source_top.sv
  - target: simulation
    files:
      - spike_source_props.sv
      - spike_source_tb.sv

// File: gen_state_ram.sv
`default_nettype none

// one state word per generator, one write port and one read port
// read data shows up two cycles after rd_en
module gen_state_ram #(
  parameter int num_gens = 16
) (
  input  logic                          clk,
  input  logic                          wr_en,
  input  logic [spike_pkg::gen_idx_w-1:0] wr_addr,
  input  logic [spike_pkg::state_w-1:0]   wr_data,
  input  logic                          rd_en,
  input  logic [spike_pkg::gen_idx_w-1:0] rd_addr,
  output logic [spike_pkg::state_w-1:0]   rd_data
);

  // depth follows the bank size
  logic [spike_pkg::state_w-1:0] mem [num_gens];
  // first stage, registered array read
  logic [spike_pkg::state_w-1:0] rd_q;

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, array read then output register
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_q <= mem[rd_addr];
    end
    rd_data <= rd_q;
  end

endmodule

`default_nettype wire

// File: spike_gen_bank.sv
`default_nettype none

// one bank of uniform spike generators
// a unit pulse walks every index below gens_used, three cycles per
// enabled generator since read and write back are not overlapped
module spike_gen_bank #(
  parameter int num_gens = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        unit_pulse,
  input  logic                        prog_valid,
  input  spike_pkg::prog_word_t       prog_word,
  output logic                        gen_spike_valid,
  output logic [spike_pkg::tag_w-1:0] gen_spike_tag,
  output logic                        overrun
);

  localparam int used_w = spike_pkg::gen_idx_w + 1;
  // gens_used from a control word is clamped to this
  localparam logic [used_w-1:0] used_max = used_w'(num_gens);

  // scan states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_read = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;
  localparam logic [1:0] st_wb = 2'd3;

  logic [1:0] state;
  logic [1:0] next_state;
  logic [spike_pkg::gen_idx_w-1:0] gen_idx;
  logic [spike_pkg::gen_idx_w-1:0] next_idx;
  // one adder shared by the read and writeback states
  logic [used_w-1:0] idx_p1;
  logic last_idx;

  // bank control registers
  logic [used_w-1:0] gens_used;
  logic [spike_pkg::max_gens-1:0] gens_en;

  // word held back while a scan runs
  logic pend_valid;
  spike_pkg::prog_word_t pend_word;
  // word applied this cycle, pending one first
  spike_pkg::prog_word_t cur_word;
  logic cur_valid;
  logic cfg_wr;
  logic ctrl_ld;

  // ram side
  logic wr_en;
  logic [spike_pkg::gen_idx_w-1:0] wr_addr;
  logic [spike_pkg::state_w-1:0] wr_data;
  logic rd_en;
  logic [spike_pkg::state_w-1:0] rd_data;

  // unpacked ram word
  logic [spike_pkg::period_w-1:0] rd_tick;
  logic [spike_pkg::period_w-1:0] rd_period;
  logic [spike_pkg::tag_w-1:0] rd_tag;
  logic [spike_pkg::period_w-1:0] wr_tick;
  logic fire;

  gen_state_ram #(
    .num_gens(num_gens)
  ) state_ram (
    .clk(clk),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_en(rd_en),
    .rd_addr(gen_idx),
    .rd_data(rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // scan fsm

  assign idx_p1 = {1'b0, gen_idx} + 1'b1;
  assign last_idx = (idx_p1 >= gens_used);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
      gen_idx <= '0;
    end else begin
      state <= next_state;
      gen_idx <= next_idx;
    end
  end

  always_comb begin
    next_state = state;
    next_idx = gen_idx;
    rd_en = 1'b0;
    case (state)
      st_idle: begin
        next_idx = '0;
        // empty bank, nothing to walk
        if (unit_pulse && gens_used != '0) begin
          next_state = st_read;
        end
      end
      st_read: begin
        if (gens_en[gen_idx]) begin
          rd_en = 1'b1;
          next_state = st_wait;
        end else if (last_idx) begin
          // disabled index costs one cycle
          next_state = st_idle;
        end else begin
          next_idx = idx_p1[spike_pkg::gen_idx_w-1:0];
        end
      end
      st_wait: begin
        // data moves into the ram output register
        next_state = st_wb;
      end
      default: begin
        if (last_idx) begin
          next_state = st_idle;
        end else begin
          next_state = st_read;
          next_idx = idx_p1[spike_pkg::gen_idx_w-1:0];
        end
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // program words

  assign cur_valid = (state == st_idle) && (pend_valid || prog_valid);
  assign cur_word = pend_valid ? pend_word : prog_word;
  // drop config words aimed past the ram depth
  assign cfg_wr = cur_valid && cur_word.cfg.kind == spike_pkg::prog_kind_cfg &&
                  {1'b0, cur_word.cfg.gen_idx} < used_max;
  assign ctrl_ld = cur_valid && cur_word.ctrl.kind == spike_pkg::prog_kind_ctrl;

  // pending flag, a newer word during a scan replaces the older one
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pend_valid <= 1'b0;
    end else if (state != st_idle) begin
      if (prog_valid) begin
        pend_valid <= 1'b1;
      end
    end else if (pend_valid) begin
      // pending word goes out now, a fresh one waits its turn
      pend_valid <= prog_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (prog_valid && (state != st_idle || pend_valid)) begin
      pend_word <= prog_word;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      gens_used <= '0;
      gens_en <= '0;
    end else if (ctrl_ld) begin
      gens_used <= (cur_word.ctrl.gens_used > used_max) ? used_max : cur_word.ctrl.gens_used;
      gens_en <= cur_word.ctrl.gens_en;
    end
  end

  // sticky, pulse arrived before the previous scan finished
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      overrun <= 1'b0;
    end else if (unit_pulse && state != st_idle) begin
      overrun <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // writeback datapath

  assign {rd_tick, rd_period, rd_tag} = rd_data;

  // tick counts up to the period, then wraps to 1 and fires
  assign fire = (rd_tick >= rd_period);
  assign wr_tick = fire ? spike_pkg::period_w'(1) : rd_tick + 1'b1;

  // ram writes come from writeback or from a config word in idle
  assign wr_en = cfg_wr || (state == st_wb);
  assign wr_addr = (state == st_wb) ? gen_idx : cur_word.cfg.gen_idx;
  assign wr_data = (state == st_wb) ? {wr_tick, rd_period, rd_tag} :
                   {cur_word.cfg.ticks, cur_word.cfg.period, cur_word.cfg.tag};

  // spike strobe in the writeback cycle
  assign gen_spike_valid = (state == st_wb) && fire;
  assign gen_spike_tag = rd_tag;

endmodule

`default_nettype wire

// File: spike_merge.sv
`default_nettype none

// folds the spike strobes of two banks into one stream
// bank a goes ahead of bank b on a tie
module spike_merge (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        a_valid,
  input  logic [spike_pkg::tag_w-1:0] a_tag,
  input  logic                        b_valid,
  input  logic [spike_pkg::tag_w-1:0] b_tag,
  output logic                        spike_valid,
  output logic                        spike_bank,
  output logic [spike_pkg::tag_w-1:0] spike_tag
);

  // entry is {bank, tag}
  localparam int entry_w = spike_pkg::tag_w + 1;

  // two-entry queue, q[0] is the head
  logic [entry_w-1:0] q [2];
  logic [1:0] count;

  // queued entries then this cycle's arrivals, in output order
  logic [entry_w-1:0] cand [4];
  logic [2:0] n_cand;

  //////////////////////////////////////////////////////////////////////
  // candidate list

  always_comb begin
    cand[0] = q[0];
    cand[1] = q[1];
    cand[2] = '0;
    cand[3] = '0;
    n_cand = {1'b0, count};
    if (a_valid) begin
      cand[n_cand[1:0]] = {1'b0, a_tag};
      n_cand = n_cand + 1'b1;
    end
    if (b_valid) begin
      cand[n_cand[1:0]] = {1'b1, b_tag};
      n_cand = n_cand + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pop one per cycle, the rest stays queued

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
      spike_valid <= 1'b0;
    end else begin
      spike_valid <= (n_cand != '0);
      if (n_cand == '0) begin
        count <= '0;
      end else if (n_cand > 3'd3) begin
        // more than fits, last entry is lost
        count <= 2'd2;
      end else begin
        count <= 2'(n_cand - 3'd1);
      end
    end
  end

  // head goes to the output registers, queue shifts up
  always_ff @(posedge clk) begin
    {spike_bank, spike_tag} <= cand[0];
    q[0] <= cand[1];
    q[1] <= cand[2];
  end

endmodule

`default_nettype wire

// File: spike_pkg.sv
`default_nettype none

package spike_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths

  // generators per bank at most, also the width of the enable mask
  localparam int max_gens = 16;
  // generator index within a bank
  localparam int gen_idx_w = 4;
  // tick and period counters share one width
  localparam int period_w = 8;
  // tag carried by every spike event
  localparam int tag_w = 10;
  // ram word is {tick, period, tag}
  localparam int state_w = 2 * period_w + tag_w;

  //////////////////////////////////////////////////////////////////////
  // program word

  // msb of the word picks the decoding
  localparam logic prog_kind_cfg = 1'b0;
  localparam logic prog_kind_ctrl = 1'b1;

  // loads one generator's ram word
  typedef struct packed {
    logic kind;
    logic bank;
    logic [gen_idx_w-1:0] gen_idx;
    logic [period_w-1:0] ticks;
    logic [period_w-1:0] period;
    logic [tag_w-1:0] tag;
  } prog_cfg_t;

  // sets the scan length and the enable mask of one bank
  typedef struct packed {
    logic kind;
    logic bank;
    logic [gen_idx_w:0] gens_used;
    logic [8:0] pad;
    logic [max_gens-1:0] gens_en;
  } prog_ctrl_t;

  // kind and bank sit at bits 31 and 30 in both views
  typedef union packed {
    prog_cfg_t cfg;
    prog_ctrl_t ctrl;
  } prog_word_t;

endpackage

`default_nettype wire

// File: spike_source.f
spike_pkg.sv
gen_state_ram.sv
spike_gen_bank.sv
spike_merge.sv
spike_source_top.sv
spike_source_props.sv
spike_source_tb.sv

// File: spike_source_props.sv
`default_nettype none

// merge queue and scan timing checks bound into the merge and each bank
module spike_source_props (
  input logic                            clk,
  input logic                            reset,
  input logic [2:0]                      q_demand,
  input logic                            out_valid,
  input logic                            out_bank,
  input logic [1:0]                      scan_state,
  input logic                            rd_en,
  input logic [spike_pkg::gen_idx_w-1:0] rd_addr,
  input logic                            wr_en,
  input logic [spike_pkg::gen_idx_w-1:0] wr_addr
);

  // count of failed assertions seen by the testbench
  int unsigned fail_count = 0;

  // held entries plus arrivals fit the queue and the output register
  no_overflow: assert property (@(posedge clk) disable iff (reset)
    q_demand <= 3'd3)
    else begin
      $error("merge queue overflow");
      fail_count = fail_count + 1;
    end

  // a bank strobes at most once every three cycles
  // so back to back outputs of one bank mean an entry was shown twice
  no_repeat: assert property (@(posedge clk) disable iff (reset)
    out_valid && $past(out_valid) |-> out_bank != $past(out_bank))
    else begin
      $error("merge output held one queue entry for two cycles");
      fail_count = fail_count + 1;
    end

  // writeback targets the index whose ram read started two cycles earlier
  wb_after_read: assert property (@(posedge clk) disable iff (reset)
    scan_state == 2'd3 |-> wr_en && $past(rd_en, 2) && $past(rd_addr, 2) == wr_addr)
    else begin
      $error("bank writeback not two cycles after its read");
      fail_count = fail_count + 1;
    end

endmodule

bind spike_merge spike_source_props merge_props (
  .clk(clk),
  .reset(reset),
  .q_demand(n_cand),
  .out_valid(spike_valid),
  .out_bank(spike_bank),
  .scan_state(2'd0),
  .rd_en(1'b0),
  .rd_addr('0),
  .wr_en(1'b0),
  .wr_addr('0)
);

bind spike_gen_bank spike_source_props bank_props (
  .clk(clk),
  .reset(reset),
  .q_demand(3'd0),
  .out_valid(1'b0),
  .out_bank(1'b0),
  .scan_state(state),
  .rd_en(rd_en),
  .rd_addr(gen_idx),
  .wr_en(wr_en),
  .wr_addr(wr_addr)
);

`default_nettype wire

// File: spike_source_tb.sv
`default_nettype none

module spike_source_tb;

  localparam int num_gens = 16;
  localparam int clk_period = 40;
  // gaps at least this long get a random stretch of 0 to 7 cycles
  localparam int stretch_min = 20;

  logic clk = 1'b0;
  logic reset;
  logic unit_pulse;
  logic prog_valid;
  logic [31:0] prog_word;
  logic spike_valid;
  logic spike_bank;
  logic [spike_pkg::tag_w-1:0] spike_tag;
  logic [1:0] overrun;

  // commands from the vector file
  logic [7:0] cmd_kind [$];
  int unsigned cmd_a [$];
  int unsigned cmd_b [$];
  int watchdog_cycles = 200;
  bit loaded = 1'b0;
  int cyc = 0;
  int unsigned lcg_state = 32'hd09a;

  // reference model indexed by bank first
  logic [7:0] m_tick [2][num_gens];
  logic [7:0] m_period [2][num_gens];
  logic [9:0] m_tag [2][num_gens];
  int m_used [2];
  logic [15:0] m_en [2];
  // last cycle of the running scan
  int busy_until [2];
  logic [9:0] exp0 [$];
  logic [9:0] exp1 [$];

  spike_source_top #(
    .num_gens(num_gens)
  ) dut (
    .clk(clk),
    .reset(reset),
    .unit_pulse(unit_pulse),
    .prog_valid(prog_valid),
    .prog_word(prog_word),
    .spike_valid(spike_valid),
    .spike_bank(spike_bank),
    .spike_tag(spike_tag),
    .overrun(overrun)
  );

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // failures of the bound assertions summed over the merge and both banks
  function automatic int unsigned assert_failures();
    return dut.merge.merge_props.fail_count + dut.bank0.bank_props.fail_count +
           dut.bank1.bank_props.fail_count;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // strobes drop at the first falling edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      unit_pulse = 1'b0;
      prog_valid = 1'b0;
    end
  endtask

  // decode by bit position with kind at 31 and bank at 30
  task automatic model_program(input logic [31:0] w);
    int b;
    int i;
    b = w[30];
    if (w[31]) begin
      m_used[b] = (w[29:25] > num_gens) ? num_gens : w[29:25];
      m_en[b] = w[15:0];
    end else begin
      i = w[29:26];
      m_tick[b][i] = w[25:18];
      m_period[b][i] = w[17:10];
      m_tag[b][i] = w[9:0];
    end
  endtask

  // an accepted pulse walks the bank at 3 cycles per enabled index and 1 per disabled one
  task automatic model_pulse(input int b, input int now);
    int len;
    int i;
    len = 0;
    if (m_used[b] != 0 && now > busy_until[b]) begin
      for (i = 0; i < m_used[b]; i++) begin
        if (m_en[b][i]) begin
          len = len + 3;
          if (m_tick[b][i] >= m_period[b][i]) begin
            m_tick[b][i] = 8'd1;
            if (b == 0) exp0.push_back(m_tag[b][i]);
            else exp1.push_back(m_tag[b][i]);
          end else begin
            m_tick[b][i] = m_tick[b][i] + 8'd1;
          end
        end else begin
          len = len + 1;
        end
      end
      busy_until[b] = now + len;
    end
  endtask

  task automatic send_pulses(input int count, input int gap);
    int j;
    int ext;
    for (j = 0; j < count; j++) begin
      if (j != 0) @(negedge clk);
      unit_pulse = 1'b1;
      prog_valid = 1'b0;
      model_pulse(0, cyc);
      model_pulse(1, cyc);
      ext = gap;
      if (gap >= stretch_min) ext = gap + int'((lcg_next() >> 16) % 8);
      idle_cycles(ext);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor matching events per bank

  always @(negedge clk) begin
    if (!reset && spike_valid === 1'b1) begin
      if (spike_bank == 1'b0 && exp0.size() == 0) begin
        abort_run("bank 0 spike arrived with none expected");
      end else if (spike_bank == 1'b1 && exp1.size() == 0) begin
        abort_run("bank 1 spike arrived with none expected");
      end else if (spike_bank == 1'b0) begin
        check_value("bank 0 tag", exp0.pop_front(), spike_tag);
      end else begin
        check_value("bank 1 tag", exp1.pop_front(), spike_tag);
      end
    end
  end

  always @(negedge clk) begin
    if (assert_failures() != 0) begin
      abort_run("an assertion on the merge queue or a bank scan failed");
    end
  end

  initial begin
    wait (loaded);
    #(watchdog_cycles * clk_period);
    abort_run("timeout, the run took longer than the vectors allow");
  end

  initial begin
    int fd;
    int n;
    int k;
    int unsigned a;
    int unsigned b;
    logic [8*16-1:0] tok;
    logic [8*200-1:0] line_buf;
    reset = 1'b1;
    unit_pulse = 1'b0;
    prog_valid = 1'b0;
    prog_word = '0;
    m_used = '{0, 0};
    m_en = '{16'h0, 16'h0};
    busy_until = '{0, 0};
    fd = $fopen("spike_source_vectors.txt", "r");
    if (fd == 0) abort_run("cannot open spike_source_vectors.txt");
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) break;
      b = 0;
      if (tok == "p" || tok == "o") begin
        n = $fscanf(fd, "%h", a);
      end else if (tok == "u") begin
        n = $fscanf(fd, "%d %d", a, b);
        watchdog_cycles = watchdog_cycles + a * (b + 8);
      end else if (tok == "w") begin
        n = $fscanf(fd, "%d", a);
        watchdog_cycles = watchdog_cycles + a;
      end else begin
        // comment line
        n = $fgets(line_buf, fd);
        continue;
      end
      cmd_kind.push_back(tok[7:0]);
      cmd_a.push_back(a);
      cmd_b.push_back(b);
      watchdog_cycles = watchdog_cycles + 1;
    end
    $fclose(fd);
    loaded = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    for (k = 0; k < cmd_kind.size(); k++) begin
      @(negedge clk);
      unit_pulse = 1'b0;
      prog_valid = 1'b0;
      case (cmd_kind[k])
        "p": begin
          prog_valid = 1'b1;
          prog_word = cmd_a[k];
          model_program(cmd_a[k]);
        end
        "u": send_pulses(cmd_a[k], cmd_b[k]);
        "w": idle_cycles(cmd_a[k]);
        default: check_value("overrun", cmd_a[k], overrun);
      endcase
    end
    idle_cycles(1);
    while (exp0.size() != 0 || exp1.size() != 0) @(negedge clk);
    // quiet tail so a late event still reaches the monitor
    idle_cycles(20);
    if (exp0.size() != 0 || exp1.size() != 0) begin
      abort_run("expected spikes were never seen");
    end else if (assert_failures() != 0) begin
      abort_run("an assertion on the merge queue or a bank scan failed");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: spike_source_top.sv
`default_nettype none

// two banks of spike generators sharing one output stream
module spike_source_top #(
  parameter int num_gens = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        unit_pulse,
  input  logic                        prog_valid,
  input  logic [31:0]                 prog_word,
  output logic                        spike_valid,
  output logic                        spike_bank,
  output logic [spike_pkg::tag_w-1:0] spike_tag,
  output logic [1:0]                  overrun
);

  spike_pkg::prog_word_t word;
  // per-bank program strobes
  logic prog_valid_0;
  logic prog_valid_1;

  logic spike_valid_0;
  logic spike_valid_1;
  logic [spike_pkg::tag_w-1:0] spike_tag_0;
  logic [spike_pkg::tag_w-1:0] spike_tag_1;

  assign word = spike_pkg::prog_word_t'(prog_word);

  // bank bit lives in the same place in both decodings
  assign prog_valid_0 = prog_valid && !word.cfg.bank;
  assign prog_valid_1 = prog_valid && word.cfg.bank;

  spike_gen_bank #(
    .num_gens(num_gens)
  ) bank0 (
    .clk(clk),
    .reset(reset),
    .unit_pulse(unit_pulse),
    .prog_valid(prog_valid_0),
    .prog_word(word),
    .gen_spike_valid(spike_valid_0),
    .gen_spike_tag(spike_tag_0),
    .overrun(overrun[0])
  );

  spike_gen_bank #(
    .num_gens(num_gens)
  ) bank1 (
    .clk(clk),
    .reset(reset),
    .unit_pulse(unit_pulse),
    .prog_valid(prog_valid_1),
    .prog_word(word),
    .gen_spike_valid(spike_valid_1),
    .gen_spike_tag(spike_tag_1),
    .overrun(overrun[1])
  );

  // bank0 on the priority side
  spike_merge merge (
    .clk(clk),
    .reset(reset),
    .a_valid(spike_valid_0),
    .a_tag(spike_tag_0),
    .b_valid(spike_valid_1),
    .b_tag(spike_tag_1),
    .spike_valid(spike_valid),
    .spike_bank(spike_bank),
    .spike_tag(spike_tag)
  );

endmodule

`default_nettype wire

// File: spike_source_vectors.txt
# p <hex word> : program word | u <count> <gap> : pulses, each then gap idle cycles
# w <cycles> : idle cycles | o <hex> : expected overrun {bank1, bank0}
p 00000C11
p 04080822
p 08040433
p 0C040444
p 8600000F
p 40000C11
p 44080822
p 48040433
p 4C040444
p C600000F
u 9 40
o 0
p 8600000B
u 2 40
u 1 2
p 04040455
w 20
u 2 40
p E000000F
u 1 10
u 1 40
o 2
u 1 40
o 2
